/* rtl/scdPkg.sv */
package scdPkg;

  // Word and field widths
  localparam int ArWidth    = 36;
  localparam int CountWidth = 10;
  localparam int MagicWidth = 9;

  // Bit 35 is the sign, the leftmost bit of the word
  typedef logic [ArWidth-1:0]    arWordT;
  typedef logic [CountWidth-1:0] countT;
  typedef logic [MagicWidth-1:0] magicT;

  // SCAD adder functions in microcode order
  typedef enum logic [2:0] {
    scadA             = 3'd0,
    scadAMinusBMinus1 = 3'd1,
    scadAPlusB        = 3'd2,
    scadAMinus1       = 3'd3,
    scadAPlus1        = 3'd4,
    scadAMinusB       = 3'd5,
    scadOr            = 3'd6,
    scadAnd           = 3'd7
  } scadFuncE;

  typedef enum logic [1:0] {
    selFe     = 2'd0,
    selArExp  = 2'd1,
    selArPos  = 2'd2,
    selMagicA = 2'd3
  } scadASelE;

  typedef enum logic [1:0] {
    selSc        = 2'd0,
    selArShift   = 2'd1,
    selArHighExp = 2'd2,
    selMagicB    = 2'd3
  } scadBSelE;

  typedef enum logic [1:0] {
    feHold       = 2'd0,
    feLoad       = 2'd1,
    feShiftRight = 2'd2
  } feOpE;

  typedef enum logic [1:0] {
    scHold     = 2'd0,
    scLoadScad = 2'd1,
    scLoadFe   = 2'd2,
    scLoadAr   = 2'd3
  } scOpE;

  // Codes 6 and 7 are spare and act as hold
  typedef enum logic [2:0] {
    flagHold     = 3'd0,
    flagSetAd    = 3'd1,
    flagLoad     = 3'd2,
    flagMagic    = 3'd3,
    flagExpTest  = 3'd4,
    flagDispatch = 3'd5
  } flagOpE;

  // Microword fields used by this section
  typedef struct packed {
    scadFuncE scadFunc;
    scadASelE aSel;
    scadBSelE bSel;
    feOpE     feOp;
    scOpE     scOp;
    flagOpE   flagOp;
    magicT    magic;
  } microT;

  typedef struct packed {
    countT sum;
    logic  sign;
  } scadResultT;

  typedef struct packed {
    countT fe;
    countT sc;
    logic  feSign;
    logic  scGe36;
    logic  sc36To63;
    logic  scadZero;
  } countStateT;

  typedef struct packed {
    logic ov;
    logic cry0;
    logic cry1;
    logic fov;
    logic fxu;
    logic divChk;
    logic fpd;
    logic pcp;
    logic trapReq1;
    logic trapReq2;
    logic trapCyc1;
    logic trapCyc2;
  } pcFlagsT;

  // Status from the main adder in the data path
  typedef struct packed {
    logic adOverflow;
    logic adCarryMinus2;
    logic adCarry1;
  } adStatusT;

  typedef logic [CountWidth-1:0] diagWordT;

endpackage

/* rtl/scadAdder.sv */
`timescale 1ns/1ns

module scadAdder (
  input  logic               clk,
  input  logic               reset,
  input  scdPkg::microT      micro,
  input  scdPkg::arWordT     ar,
  input  scdPkg::countT      fe,
  input  scdPkg::countT      sc,
  output scdPkg::scadResultT scadResult
);

  // One extra bit above the count width carries the sign
  logic [scdPkg::CountWidth:0] opA;
  logic [scdPkg::CountWidth:0] opB;
  logic [scdPkg::CountWidth:0] result;

  always_comb begin
    case (micro.aSel)
      scdPkg::selFe:    opA = {fe[9], fe};
      // Exponent in magnitude form for negative words
      scdPkg::selArExp: opA = {3'b000, ar[34:27] ^ {8{ar[35]}}};
      scdPkg::selArPos: opA = {5'b00000, ar[35:30]};
      default:          opA = {{2{micro.magic[8]}}, micro.magic};
    endcase
  end

  always_comb begin
    case (micro.bSel)
      scdPkg::selSc:        opB = {sc[9], sc};
      scdPkg::selArShift:   opB = {5'b00000, ar[29:24]};
      scdPkg::selArHighExp: opB = {{2{ar[35]}}, ar[35:27]};
      default:              opB = {{2{micro.magic[8]}}, micro.magic};
    endcase
  end

  always_comb begin
    case (micro.scadFunc)
      scdPkg::scadA:             result = opA;
      scdPkg::scadAMinusBMinus1: result = opA + ~opB;
      scdPkg::scadAPlusB:        result = opA + opB;
      scdPkg::scadAMinus1:       result = opA - 11'd1;
      scdPkg::scadAPlus1:        result = opA + 11'd1;
      scdPkg::scadAMinusB:       result = opA - opB;
      scdPkg::scadOr:            result = opA | opB;
      default:                   result = opA & opB;
    endcase
  end

  always_comb begin
    scadResult.sum  = result[scdPkg::CountWidth-1:0];
    scadResult.sign = result[scdPkg::CountWidth];
  end

  // The function field feeds both count registers and the flags
  scadFuncKnown: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(micro.scadFunc)
  ) else $error("SCAD function is unknown");

endmodule

/* rtl/countRegs.sv */
`timescale 1ns/1ns

module countRegs (
  input  logic               clk,
  input  logic               reset,
  input  scdPkg::microT      micro,
  input  scdPkg::arWordT     ar,
  input  scdPkg::scadResultT scadResult,
  output scdPkg::countStateT countState
);

  scdPkg::countT fe;
  scdPkg::countT sc;
  logic          feSign;
  logic          sc36To63;

  // FE holds an exponent; shifting right keeps its sign
  always_ff @(posedge clk) begin
    if (reset) begin
      fe     <= '0;
      feSign <= 1'b0;
    end else begin
      case (micro.feOp)
        scdPkg::feLoad: begin
          fe     <= scadResult.sum;
          feSign <= scadResult.sign;
        end
        scdPkg::feShiftRight: fe <= {feSign, fe[scdPkg::CountWidth-1:1]};
        default: fe <= fe;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sc <= '0;
    end else begin
      case (micro.scOp)
        scdPkg::scLoadScad: sc <= scadResult.sum;
        scdPkg::scLoadFe:   sc <= fe;
        scdPkg::scLoadAr:   sc <= ar[scdPkg::CountWidth-1:0];
        default:            sc <= sc;
      endcase
    end
  end

  assign sc36To63 = sc[5] & |sc[4:2];

  always_comb begin
    countState.fe       = fe;
    countState.sc       = sc;
    countState.feSign   = feSign;
    countState.sc36To63 = sc36To63;
    // Either 64 and up, or in the 36 to 63 band
    countState.scGe36   = |sc[9:6] | sc36To63;
    countState.scadZero = scadResult.sum == '0;
  end

  // Microcode never shifts FE while SC copies it
  noShiftWhileCopy: assert property (
    @(posedge clk) disable iff (reset)
      !(micro.feOp == scdPkg::feShiftRight && micro.scOp == scdPkg::scLoadFe)
  ) else $error("FE shift paired with SC load from FE");

endmodule

/* rtl/pcFlags.sv */
`timescale 1ns/1ns

module pcFlags (
  input  logic               clk,
  input  logic               reset,
  input  scdPkg::microT      micro,
  input  scdPkg::arWordT     ar,
  input  scdPkg::adStatusT   adStatus,
  input  logic               trapEnable,
  input  scdPkg::scadResultT scadResult,
  output scdPkg::pcFlagsT    flags
);

  scdPkg::pcFlagsT flagsNext;
  logic            expOverflow;

  // Exponent left its range when the carry out disagrees with bit 9
  assign expOverflow = scadResult.sign ^ scadResult.sum[scdPkg::CountWidth-1];

  always_comb begin
    flagsNext = flags;
    case (micro.flagOp)
      scdPkg::flagSetAd: begin
        flagsNext.ov       = flags.ov | adStatus.adOverflow;
        flagsNext.trapReq1 = flags.trapReq1 | adStatus.adOverflow;
        flagsNext.cry0     = flags.cry0 | adStatus.adCarryMinus2;
        flagsNext.cry1     = flags.cry1 | adStatus.adCarry1;
      end
      scdPkg::flagLoad: begin
        // Flag word layout from the left end of AR
        flagsNext.ov       = ar[35];
        flagsNext.cry0     = ar[34];
        flagsNext.cry1     = ar[33];
        flagsNext.fov      = ar[32];
        flagsNext.fpd      = ar[31];
        flagsNext.pcp      = ar[30];
        flagsNext.trapReq2 = ar[29];
        flagsNext.trapReq1 = ar[28];
        flagsNext.fxu      = ar[27];
        flagsNext.divChk   = ar[26];
        flagsNext.trapCyc1 = 1'b0;
        flagsNext.trapCyc2 = 1'b0;
      end
      scdPkg::flagMagic: begin
        flagsNext.ov       = flags.ov | micro.magic[0];
        flagsNext.fov      = flags.fov | micro.magic[0];
        flagsNext.fpd      = flags.fpd | micro.magic[2];
        flagsNext.trapReq2 = flags.trapReq2 | micro.magic[3];
        flagsNext.trapReq1 = flags.trapReq1 | micro.magic[4];
        flagsNext.fxu      = flags.fxu | micro.magic[5];
        flagsNext.divChk   = flags.divChk | micro.magic[6];
      end
      scdPkg::flagExpTest: begin
        flagsNext.ov       = flags.ov | expOverflow;
        flagsNext.fov      = flags.fov | expOverflow;
        flagsNext.trapReq1 = flags.trapReq1 | expOverflow;
        flagsNext.fxu      = flags.fxu | scadResult.sign;
      end
      scdPkg::flagDispatch: begin
        if (trapEnable) begin
          flagsNext.trapCyc1 = flags.trapReq1;
          flagsNext.trapCyc2 = flags.trapReq2;
        end
        flagsNext.trapReq1 = 1'b0;
        flagsNext.trapReq2 = 1'b0;
      end
      default: flagsNext = flags;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else begin
      flags <= flagsNext;
    end
  end

  // Only one trap cycle may run at a time
  oneTrapCycle: assert property (
    @(posedge clk) disable iff (reset) !(flags.trapCyc1 && flags.trapCyc2)
  ) else $error("Both trap cycles active");

endmodule

/* rtl/diagRead.sv */
`timescale 1ns/1ns

module diagRead (
  input  logic               clk,
  input  logic               reset,
  input  logic               diagEnable,
  input  logic [2:0]         diagSel,
  input  scdPkg::countStateT countState,
  input  scdPkg::pcFlagsT    flags,
  output scdPkg::diagWordT   diag
);

  scdPkg::diagWordT word;

  // First listed bit sits highest in each packed word
  always_comb begin
    case (diagSel)
      3'd0: word = countState.sc;
      3'd1: word = countState.fe;
      3'd2: word = {2'b00, flags.ov, flags.cry0, flags.cry1, flags.fov,
                    flags.fxu, flags.divChk, flags.fpd, flags.pcp};
      3'd3: word = {2'b00, flags.trapReq1, flags.trapReq2,
                    flags.trapCyc1, flags.trapCyc2,
                    countState.scadZero, countState.scGe36,
                    countState.sc36To63, countState.feSign};
      default: word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      diag <= '0;
    end else if (diagEnable) begin
      diag <= word;
    end else begin
      diag <= '0;
    end
  end

endmodule

/* rtl/scdTop.sv */
`timescale 1ns/1ns

module scdTop (
  input  logic               clk,
  input  logic               reset,
  input  scdPkg::microT      micro,
  input  scdPkg::arWordT     ar,
  input  scdPkg::adStatusT   adStatus,
  input  logic               trapEnable,
  input  logic               diagEnable,
  input  logic [2:0]         diagSel,
  output scdPkg::countStateT countState,
  output scdPkg::pcFlagsT    flags,
  output scdPkg::diagWordT   diag
);

  scdPkg::scadResultT scadResult;

  // Exponent and shift count path
  scadAdder iScadAdder (
    .clk        (clk),
    .reset      (reset),
    .micro      (micro),
    .ar         (ar),
    .fe         (countState.fe),
    .sc         (countState.sc),
    .scadResult (scadResult)
  );

  countRegs iCountRegs (
    .clk        (clk),
    .reset      (reset),
    .micro      (micro),
    .ar         (ar),
    .scadResult (scadResult),
    .countState (countState)
  );

  pcFlags iPcFlags (
    .clk        (clk),
    .reset      (reset),
    .micro      (micro),
    .ar         (ar),
    .adStatus   (adStatus),
    .trapEnable (trapEnable),
    .scadResult (scadResult),
    .flags      (flags)
  );

  // Readout sees the registered state, so it lags one more cycle
  diagRead iDiagRead (
    .clk        (clk),
    .reset      (reset),
    .diagEnable (diagEnable),
    .diagSel    (diagSel),
    .countState (countState),
    .flags      (flags),
    .diag       (diag)
  );

endmodule

/* verification/scdVectors.svh */
// Columns: name, scadFunc, aSel, bSel, feOp, scOp, flagOp, magic, ar, adStatus,
// trapEnable, diagEnable, diagSel, then expected fe, sc, feSign, flags, diag
addRow("loadAr", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scLoadAr, scdPkg::flagHold, 9'd0, 36'd35, 3'b000, 1'b0, 1'b1, 3'd0,
       10'd0, 10'd35, 1'b0, 12'h000, 10'd35);
addRow("sc36", scdPkg::scadAPlus1, scdPkg::selMagicA, scdPkg::selSc, scdPkg::feLoad,
       scdPkg::scLoadScad, scdPkg::flagHold, 9'd35, 36'd0, 3'b000, 1'b0, 1'b1, 3'd1,
       10'd36, 10'd36, 1'b0, 12'h000, 10'd36);
addRow("sc63", scdPkg::scadAPlusB, scdPkg::selMagicA, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scLoadScad, scdPkg::flagHold, 9'd27, 36'd0, 3'b000, 1'b0, 1'b1, 3'd3,
       10'd36, 10'd63, 1'b0, 12'h000, 10'h006);
addRow("sc64", scdPkg::scadAMinusBMinus1, scdPkg::selMagicA, scdPkg::selSc,
       scdPkg::feHold, scdPkg::scLoadScad, scdPkg::flagHold, 9'd128, 36'd0, 3'b000,
       1'b0, 1'b0, 3'd1, 10'd36, 10'd64, 1'b0, 12'h000, 10'd0);
addRow("sc0", scdPkg::scadAMinusB, scdPkg::selFe, scdPkg::selMagicB, scdPkg::feLoad,
       scdPkg::scLoadScad, scdPkg::flagHold, 9'd36, 36'd0, 3'b000, 1'b0, 1'b1, 3'd3,
       10'd0, 10'd0, 1'b0, 12'h000, 10'h008);
addRow("negLoad", scdPkg::scadA, scdPkg::selMagicA, scdPkg::selSc, scdPkg::feLoad,
       scdPkg::scHold, scdPkg::flagHold, 9'h1FC, 36'd0, 3'b000, 1'b0, 1'b1, 3'd1,
       10'h3FC, 10'd0, 1'b1, 12'h000, 10'h3FC);
addRow("feShift", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feShiftRight,
       scdPkg::scHold, scdPkg::flagHold, 9'd0, 36'd0, 3'b000, 1'b0, 1'b1, 3'd1,
       10'h3FE, 10'd0, 1'b1, 12'h000, 10'h3FE);
addRow("arExp", scdPkg::scadA, scdPkg::selArExp, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scLoadScad, scdPkg::flagHold, 9'd0, {1'b1, 8'h0F, 27'd0}, 3'b000,
       1'b0, 1'b0, 3'd0, 10'h3FE, 10'd240, 1'b1, 12'h000, 10'd0);
addRow("orShift", scdPkg::scadOr, scdPkg::selArPos, scdPkg::selArShift, scdPkg::feHold,
       scdPkg::scLoadScad, scdPkg::flagHold, 9'd0, {6'd40, 6'd5, 24'd0}, 3'b000,
       1'b0, 1'b0, 3'd0, 10'h3FE, 10'd45, 1'b1, 12'h000, 10'd0);
addRow("andHighExp", scdPkg::scadAnd, scdPkg::selMagicA, scdPkg::selArHighExp,
       scdPkg::feHold, scdPkg::scLoadScad, scdPkg::flagHold, 9'h0F0, {9'd102, 27'd0},
       3'b000, 1'b0, 1'b1, 3'd0, 10'h3FE, 10'd96, 1'b1, 12'h000, 10'd96);
addRow("scFromFe", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scLoadFe, scdPkg::flagHold, 9'd0, 36'd0, 3'b000, 1'b0, 1'b1, 3'd0,
       10'h3FE, 10'h3FE, 1'b1, 12'h000, 10'h3FE);
addRow("scBig", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scLoadAr, scdPkg::flagHold, 9'd0, 36'h180, 3'b000, 1'b0, 1'b0, 3'd0,
       10'h3FE, 10'h180, 1'b1, 12'h000, 10'd0);
addRow("setAd", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scHold, scdPkg::flagSetAd, 9'd0, 36'd0, 3'b101, 1'b0, 1'b1, 3'd2,
       10'h3FE, 10'h180, 1'b1, 12'hA08, 10'h0A0);
addRow("dispatchOff", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scHold, scdPkg::flagDispatch, 9'd0, 36'd0, 3'b000, 1'b0, 1'b0, 3'd0,
       10'h3FE, 10'h180, 1'b1, 12'hA00, 10'd0);
addRow("magic", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scHold, scdPkg::flagMagic, 9'h04D, 36'd0, 3'b000, 1'b0, 1'b1, 3'd3,
       10'h3FE, 10'h180, 1'b1, 12'hB64, 10'h045);
addRow("dispatchOn", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scHold, scdPkg::flagDispatch, 9'd0, 36'd0, 3'b000, 1'b1, 1'b1, 3'd3,
       10'h3FE, 10'h180, 1'b1, 12'hB61, 10'h015);
addRow("flagLoad", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scHold, scdPkg::flagLoad, 9'd0, {12'h5AC, 24'd0}, 3'b000, 1'b0, 1'b1,
       3'd2, 10'h3FE, 10'h180, 1'b1, 12'h5E4, 10'h05E);
addRow("dispatchClear", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scHold, scdPkg::flagDispatch, 9'd0, 36'd0, 3'b000, 1'b0, 1'b1, 3'd3,
       10'h3FE, 10'h180, 1'b1, 12'h5E0, 10'h005);
addRow("expTest", scdPkg::scadAPlusB, scdPkg::selMagicA, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scHold, scdPkg::flagExpTest, 9'h0FF, 36'd0, 3'b000, 1'b0, 1'b1, 3'd2,
       10'h3FE, 10'h180, 1'b1, 12'hDE8, 10'h0DE);
addRow("dispatchReq1", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scHold, scdPkg::flagDispatch, 9'd0, 36'd0, 3'b000, 1'b1, 1'b1, 3'd3,
       10'h3FE, 10'h180, 1'b1, 12'hDE2, 10'h025);
addRow("diagSpare", scdPkg::scadA, scdPkg::selFe, scdPkg::selSc, scdPkg::feHold,
       scdPkg::scHold, scdPkg::flagHold, 9'd0, 36'd0, 3'b000, 1'b0, 1'b1, 3'd7,
       10'h3FE, 10'h180, 1'b1, 12'hDE2, 10'd0);

/* verification/tbScd.sv */
`timescale 1ns/1ns

module tbScd;

  typedef struct packed {
    scdPkg::microT    micro;
    scdPkg::arWordT   ar;
    scdPkg::adStatusT adStatus;
    logic             trapEnable;
    logic             diagEnable;
    logic [2:0]       diagSel;
    scdPkg::countT    expFe;
    scdPkg::countT    expSc;
    logic             expFeSign;
    scdPkg::pcFlagsT  expFlags;
    scdPkg::diagWordT expDiag;
  } vectorT;

  logic               clk;
  logic               reset;
  scdPkg::microT      micro;
  scdPkg::arWordT     ar;
  scdPkg::adStatusT   adStatus;
  logic               trapEnable;
  logic               diagEnable;
  logic [2:0]         diagSel;
  scdPkg::countStateT countState;
  scdPkg::pcFlagsT    flags;
  scdPkg::diagWordT   diag;

  vectorT      vectors[$];
  string       names[$];
  logic [31:0] lfsr;
  int          cycles = 0;
  int          cycleLimit = 0;

  scdTop i_dut (
    .clk        (clk),
    .reset      (reset),
    .micro      (micro),
    .ar         (ar),
    .adStatus   (adStatus),
    .trapEnable (trapEnable),
    .diagEnable (diagEnable),
    .diagSel    (diagSel),
    .countState (countState),
    .flags      (flags),
    .diag       (diag)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Simulation failed");
      $fatal(1, "Timeout");
    end
  end

  task automatic addRow(input string name, input scdPkg::scadFuncE func,
      input scdPkg::scadASelE aSel, input scdPkg::scadBSelE bSel, input scdPkg::feOpE feOp,
      input scdPkg::scOpE scOp, input scdPkg::flagOpE flagOp, input scdPkg::magicT magic,
      input scdPkg::arWordT arWord, input logic [2:0] ad, input logic te, input logic de,
      input logic [2:0] ds, input scdPkg::countT fe, input scdPkg::countT sc,
      input logic feSign, input logic [11:0] fl, input scdPkg::diagWordT d);
    vectorT v;
    v.micro.scadFunc = func;
    v.micro.aSel = aSel;
    v.micro.bSel = bSel;
    v.micro.feOp = feOp;
    v.micro.scOp = scOp;
    v.micro.flagOp = flagOp;
    v.micro.magic = magic;
    v.ar = arWord;
    v.adStatus = ad;
    v.trapEnable = te;
    v.diagEnable = de;
    v.diagSel = ds;
    v.expFe = fe;
    v.expSc = sc;
    v.expFeSign = feSign;
    v.expFlags = fl;
    v.expDiag = d;
    vectors.push_back(v);
    names.push_back(name);
  endtask

  task automatic loadVectors();
    `include "scdVectors.svh"
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] nextBits(input int count);
    logic [31:0] value;
    logic        outBit;
    value = '0;
    for (int i = 0; i < count; i++) begin
      outBit = lfsr[0];
      lfsr = lfsr >> 1;
      if (outBit) lfsr = lfsr ^ 32'h80200003;
      value = {value[30:0], outBit};
    end
    return value;
  endfunction

  function automatic scdPkg::scadResultT scadModel(input scdPkg::microT m,
      input scdPkg::arWordT a, input scdPkg::countT fe, input scdPkg::countT sc);
    logic signed [10:0] opA;
    logic signed [10:0] opB;
    logic signed [10:0] r;
    logic [7:0]         expField;
    scdPkg::scadResultT res;
    expField = a[35] ? ~a[34:27] : a[34:27];
    case (m.aSel)
      scdPkg::selFe:    opA = $signed(fe);
      scdPkg::selArExp: opA = expField;
      scdPkg::selArPos: opA = a[35:30];
      default:          opA = $signed(m.magic);
    endcase
    case (m.bSel)
      scdPkg::selSc:        opB = $signed(sc);
      scdPkg::selArShift:   opB = a[29:24];
      scdPkg::selArHighExp: opB = $signed(a[35:27]);
      default:              opB = $signed(m.magic);
    endcase
    case (m.scadFunc)
      scdPkg::scadA:             r = opA;
      scdPkg::scadAMinusBMinus1: r = opA - opB - 11'sd1;
      scdPkg::scadAPlusB:        r = opA + opB;
      scdPkg::scadAMinus1:       r = opA - 11'sd1;
      scdPkg::scadAPlus1:        r = opA + 11'sd1;
      scdPkg::scadAMinusB:       r = opA - opB;
      scdPkg::scadOr:            r = opA | opB;
      default:                   r = opA & opB;
    endcase
    res.sum = r[9:0];
    res.sign = r[10];
    return res;
  endfunction

  // SCAD sees a hold microword while results are sampled, so its sum is FE
  function automatic scdPkg::countStateT expectCount(input scdPkg::countT fe,
      input scdPkg::countT sc, input logic feSign);
    scdPkg::countStateT cs;
    cs.fe = fe;
    cs.sc = sc;
    cs.feSign = feSign;
    cs.scGe36 = sc >= 10'd36;
    cs.sc36To63 = sc[5:0] >= 6'd36;
    cs.scadZero = fe == 10'd0;
    return cs;
  endfunction

  function automatic scdPkg::diagWordT diagModel(input logic en, input logic [2:0] sel,
      input scdPkg::countStateT cs, input scdPkg::pcFlagsT fl);
    if (!en) return '0;
    case (sel)
      3'd0: return cs.sc;
      3'd1: return cs.fe;
      3'd2: return {2'b00, fl.ov, fl.cry0, fl.cry1, fl.fov, fl.fxu, fl.divChk, fl.fpd, fl.pcp};
      3'd3: return {2'b00, fl.trapReq1, fl.trapReq2, fl.trapCyc1, fl.trapCyc2,
                    cs.scadZero, cs.scGe36, cs.sc36To63, cs.feSign};
      default: return '0;
    endcase
  endfunction

  task automatic checkCount(input string name, input scdPkg::countStateT exp,
      input scdPkg::countStateT act);
    if (act !== exp) begin
      $display("[ERROR] %s countState expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "countState mismatch");
    end
  endtask

  task automatic checkFlags(input string name, input scdPkg::pcFlagsT exp,
      input scdPkg::pcFlagsT act);
    if (act !== exp) begin
      $display("[ERROR] %s flags expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "flags mismatch");
    end
  endtask

  task automatic checkDiag(input string name, input scdPkg::diagWordT exp,
      input scdPkg::diagWordT act);
    if (act !== exp) begin
      $display("[ERROR] %s diag expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "diag mismatch");
    end
  endtask

  // Count and flags one cycle after the microword, diag one cycle later
  task automatic applyRow(input string name, input vectorT v);
    @(posedge clk);
    micro <= v.micro;
    ar <= v.ar;
    adStatus <= v.adStatus;
    trapEnable <= v.trapEnable;
    diagEnable <= v.diagEnable;
    diagSel <= v.diagSel;
    @(posedge clk);
    micro <= '0;
    ar <= '0;
    adStatus <= '0;
    trapEnable <= 1'b0;
    @(negedge clk);
    checkCount(name, expectCount(v.expFe, v.expSc, v.expFeSign), countState);
    checkFlags(name, v.expFlags, flags);
    @(posedge clk);
    @(negedge clk);
    checkDiag(name, v.expDiag, diag);
  endtask

  initial begin
    vectorT             v;
    scdPkg::scadResultT res;
    scdPkg::countT      mFe;
    scdPkg::countT      mSc;
    logic               mFeSign;
    scdPkg::pcFlagsT    mFlags;
    logic [2:0]         funcBits;
    logic [1:0]         aBits;
    logic [1:0]         bBits;
    reset = 1'b1;
    micro = '0;
    ar = '0;
    adStatus = '0;
    trapEnable = 1'b0;
    diagEnable = 1'b0;
    diagSel = 3'd0;
    lfsr = 32'h511c;
    loadVectors();
    cycleLimit = (vectors.size() + 64) * 4 + 20;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkCount("reset", expectCount(10'd0, 10'd0, 1'b0), countState);
    checkFlags("reset", '0, flags);
    checkDiag("reset", '0, diag);
    foreach (vectors[i]) applyRow(names[i], vectors[i]);
    mFe = vectors[vectors.size()-1].expFe;
    mSc = vectors[vectors.size()-1].expSc;
    mFeSign = vectors[vectors.size()-1].expFeSign;
    mFlags = vectors[vectors.size()-1].expFlags;
    for (int n = 0; n < 64; n++) begin
      v = '0;
      funcBits = nextBits(3);
      aBits = nextBits(2);
      bBits = nextBits(2);
      v.micro.scadFunc = scdPkg::scadFuncE'(funcBits);
      v.micro.aSel = scdPkg::scadASelE'(aBits);
      v.micro.bSel = scdPkg::scadBSelE'(bBits);
      v.micro.feOp = nextBits(1) ? scdPkg::feLoad : scdPkg::feHold;
      v.micro.scOp = nextBits(1) ? scdPkg::scLoadScad : scdPkg::scLoadAr;
      v.micro.flagOp = nextBits(1) ? scdPkg::flagExpTest : scdPkg::flagHold;
      v.micro.magic = nextBits(9);
      v.ar[35:32] = nextBits(4);
      v.ar[31:0] = nextBits(32);
      v.diagEnable = nextBits(1);
      v.diagSel = nextBits(3);
      res = scadModel(v.micro, v.ar, mFe, mSc);
      if (v.micro.feOp == scdPkg::feLoad) begin
        mFe = res.sum;
        mFeSign = res.sign;
      end
      mSc = (v.micro.scOp == scdPkg::scLoadScad) ? res.sum : v.ar[9:0];
      if (v.micro.flagOp == scdPkg::flagExpTest) begin
        if (res.sign != res.sum[9]) begin
          mFlags.ov = 1'b1;
          mFlags.fov = 1'b1;
          mFlags.trapReq1 = 1'b1;
        end
        if (res.sign) mFlags.fxu = 1'b1;
      end
      v.expFe = mFe;
      v.expSc = mSc;
      v.expFeSign = mFeSign;
      v.expFlags = mFlags;
      v.expDiag = diagModel(v.diagEnable, v.diagSel, expectCount(mFe, mSc, mFeSign), mFlags);
      applyRow($sformatf("random%0d", n), v);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* all.f */
+incdir+verification
rtl/scdPkg.sv
rtl/scadAdder.sv
rtl/countRegs.sv
rtl/pcFlags.sv
rtl/diagRead.sv
rtl/scdTop.sv
verification/tbScd.sv
